// ==== rtl/spl_rx_pkg.sv ====
// ------------------------------
// spinnaker link receiver types
// widths, flit and packet layouts
// ------------------------------
`default_nettype none

package spl_rx_pkg;

  // ------------------------------
  // widths and lengths
  // ------------------------------

  // link data wires, 2-of-7 nrz
  localparam int spl_sym_w = 7;
  // one data flit carries a nibble
  localparam int spl_nib_w = 4;
  // full long packet
  localparam int spl_pkt_w = 72;

  // data flits before end-of-packet
  localparam int spl_short_flits = 10;
  localparam int spl_long_flits  = 18;

  // wire change pattern for end-of-packet (wires 5 and 6)
  localparam logic [spl_sym_w-1:0] spl_eop_sym = 7'b1100000;

  // ------------------------------
  // decoded flit
  // ------------------------------

  // nib is zero when eop is set
  typedef struct packed {
    logic                 eop;
    logic [spl_nib_w-1:0] nib;
  } spl_flit_t;

  // ------------------------------
  // packet, header in the low byte
  // ------------------------------

  // hdr[1] marks payload present, hdr[0] makes the packet xor odd
  typedef struct packed {
    logic [31:0] pld;
    logic [31:0] key;
    logic [7:0]  hdr;
  } spl_pkt_t;

endpackage

`default_nettype wire

// ==== rtl/spl_flit_decoder.sv ====
// ------------------------------
// 2-of-7 nrz symbol decoder
// turns wire changes into flits, toggles ack
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module spl_flit_decoder
  import spl_rx_pkg::*;
(
  input  logic                 tb_clk,
  input  logic                 tb_rst,
  input  logic [spl_sym_w-1:0] data,
  input  logic                 full,
  output logic                 ack,
  output spl_flit_t            flit,
  output logic                 flit_stb,
  output logic                 flit_bad,
  output logic                 flt_err
);

  // ------------------------------
  // code table
  // ------------------------------

  // result is {legal, eop, nib}
  function automatic logic [spl_nib_w+1:0] decode_2of7(input logic [spl_sym_w-1:0] chg);
    case (chg)
      7'b0010001:  decode_2of7 = {1'b1, 1'b0, 4'h0};
      7'b0010010:  decode_2of7 = {1'b1, 1'b0, 4'h1};
      7'b0010100:  decode_2of7 = {1'b1, 1'b0, 4'h2};
      7'b0011000:  decode_2of7 = {1'b1, 1'b0, 4'h3};
      7'b0100001:  decode_2of7 = {1'b1, 1'b0, 4'h4};
      7'b0100010:  decode_2of7 = {1'b1, 1'b0, 4'h5};
      7'b0100100:  decode_2of7 = {1'b1, 1'b0, 4'h6};
      7'b0101000:  decode_2of7 = {1'b1, 1'b0, 4'h7};
      7'b1000001:  decode_2of7 = {1'b1, 1'b0, 4'h8};
      7'b1000010:  decode_2of7 = {1'b1, 1'b0, 4'h9};
      7'b1000100:  decode_2of7 = {1'b1, 1'b0, 4'ha};
      7'b1001000:  decode_2of7 = {1'b1, 1'b0, 4'hb};
      7'b0000011:  decode_2of7 = {1'b1, 1'b0, 4'hc};
      7'b0000110:  decode_2of7 = {1'b1, 1'b0, 4'hd};
      7'b0001100:  decode_2of7 = {1'b1, 1'b0, 4'he};
      7'b0001001:  decode_2of7 = {1'b1, 1'b0, 4'hf};
      spl_eop_sym: decode_2of7 = {1'b1, 1'b1, 4'h0};
      // unused pairs and glitches
      default:     decode_2of7 = '0;
    endcase
  endfunction

  // number of wires that changed
  function automatic logic [2:0] count_ones(input logic [spl_sym_w-1:0] v);
    logic [2:0] n;
    n = '0;
    for (int i = 0; i < spl_sym_w; i++)
    begin
      n = n + 3'(v[i]);
    end
    return n;
  endfunction

  // ------------------------------
  // change detection
  // ------------------------------

  // sampled wires and last accepted wire value
  logic [spl_sym_w-1:0]   data_q;
  logic [spl_sym_w-1:0]   ref_q;
  logic [spl_sym_w-1:0]   chg;
  logic [spl_nib_w+1:0]   dec;
  logic                   take;
  logic                   legal;

  assign chg   = data_q ^ ref_q;
  assign dec   = decode_2of7(chg);
  // one changed wire means the symbol is still half way
  assign take  = (count_ones(chg) >= 3'd2) && !full;
  assign legal = dec[spl_nib_w+1];

  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      data_q   <= '0;
      ref_q    <= '0;
      ack      <= 1'b0;
      flit_stb <= 1'b0;
      flit_bad <= 1'b0;
    end
    else
    begin
      data_q   <= data;
      flit_stb <= take;
      // bad symbols are acked too so the sender keeps going
      flit_bad <= take && !legal;
      if (take)
      begin
        ref_q <= data_q;
        ack   <= ~ack;
      end
    end
  end

  // flit value, zero for an illegal symbol
  always_ff @(posedge tb_clk)
  begin
    if (take)
      flit <= legal ? spl_flit_t'(dec[spl_nib_w:0]) : '0;
  end

  assign flt_err = flit_bad;

endmodule

`default_nettype wire

// ==== rtl/spl_pkt_assembler.sv ====
// ------------------------------
// packet assembler
// builds packets from flits, checks length and parity
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module spl_pkt_assembler
  import spl_rx_pkg::*;
(
  input  logic      tb_clk,
  input  logic      tb_rst,
  input  spl_flit_t flit,
  input  logic      flit_stb,
  input  logic      flit_bad,
  output spl_pkt_t  wr_pkt,
  output logic      wr_stb,
  output logic      frm_err
);

  // counter holds 0 up to a full long packet
  localparam int cnt_w   = $clog2(spl_long_flits + 1);
  // header plus key
  localparam int short_w = spl_short_flits * spl_nib_w;

  localparam logic [cnt_w-1:0] short_cnt = cnt_w'(spl_short_flits);
  localparam logic [cnt_w-1:0] long_cnt  = cnt_w'(spl_long_flits);

  // ------------------------------
  // frame state
  // ------------------------------

  logic [spl_pkt_w-1:0] sreg;
  spl_pkt_t             cur;
  logic [cnt_w-1:0]     cnt;
  logic                 bad_q;

  logic                 eop_now;
  logic                 data_now;
  logic                 ovr;
  logic                 long_pkt;
  logic                 len_ok;
  logic                 par_ok;
  logic                 pkt_ok;

  assign cur      = sreg;
  assign eop_now  = flit_stb && flit.eop;
  assign data_now = flit_stb && !flit.eop;
  // a data flit beyond a long packet
  assign ovr      = data_now && (cnt == long_cnt);

  // header bit 1 selects the long format
  assign long_pkt = cur.hdr[1];
  assign len_ok   = long_pkt ? (cnt == long_cnt) : (cnt == short_cnt);
  // xor over all packet bits has to be odd
  assign par_ok   = long_pkt ? ^sreg : ^sreg[short_w-1:0];
  assign pkt_ok   = len_ok && par_ok && !bad_q;

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      cnt     <= '0;
      bad_q   <= 1'b0;
      wr_stb  <= 1'b0;
      frm_err <= 1'b0;
    end
    else
    begin
      wr_stb  <= eop_now && pkt_ok;
      frm_err <= eop_now && !pkt_ok;
      if (eop_now)
      begin
        // start a fresh frame
        cnt   <= '0;
        bad_q <= 1'b0;
      end
      else if (data_now)
      begin
        if (flit_bad || ovr)
          bad_q <= 1'b1;
        // count saturates on overrun
        if (!ovr)
          cnt <= cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // packet data
  // ------------------------------

  // nibbles land low first, stale upper bits stay unused for short packets
  always_ff @(posedge tb_clk)
  begin
    if (data_now && !ovr)
      sreg[cnt*spl_nib_w +: spl_nib_w] <= flit.nib;
    if (eop_now)
    begin
      wr_pkt.hdr <= cur.hdr;
      wr_pkt.key <= cur.key;
      wr_pkt.pld <= long_pkt ? cur.pld : '0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spl_pkt_fifo.sv ====
// ------------------------------
// fall-through packet FIFO
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module spl_pkt_fifo #(
  parameter type item_t     = logic [71:0],
  parameter int  fifo_depth = 4
) (
  input  logic  tb_clk,
  input  logic  tb_rst,
  input  item_t wr_item,
  input  logic  wr_stb,
  output item_t rd_item,
  output logic  rd_vld,
  input  logic  rd_rdy,
  output logic  full
);

  // depth is a power of two, pointers carry one wrap bit
  localparam int addr_w = $clog2(fifo_depth);

  item_t             mem [fifo_depth];
  logic [addr_w:0]   wr_ptr;
  logic [addr_w:0]   rd_ptr;
  logic              empty;
  logic              rd_en;

  assign empty = (wr_ptr == rd_ptr);
  // same slot, different lap
  assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w])
              && (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

  // head item shown directly
  assign rd_vld  = !empty;
  assign rd_item = mem[rd_ptr[addr_w-1:0]];
  assign rd_en   = rd_vld && rd_rdy;

  // ------------------------------
  // pointers
  // ------------------------------

  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_stb)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage
  always_ff @(posedge tb_clk)
  begin
    if (wr_stb)
      mem[wr_ptr[addr_w-1:0]] <= wr_item;
  end

endmodule

`default_nettype wire

// ==== rtl/spl_rx_top.sv ====
// ------------------------------
// spinnaker link receiver
// 2-of-7 link in, valid/ready packets out
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module spl_rx_top
  import spl_rx_pkg::*;
#(
  parameter int fifo_depth = 4
) (
  input  logic                 tb_clk,
  input  logic                 tb_rst,

  // link side
  input  logic [spl_sym_w-1:0] data,
  output logic                 ack,

  // packet side
  output spl_pkt_t             pkt,
  output logic                 pkt_vld,
  input  logic                 pkt_rdy,

  // error pulses
  output logic                 flt_err,
  output logic                 frm_err
);

  // decoder to assembler
  spl_flit_t flit;
  logic      flit_stb;
  logic      flit_bad;

  // assembler to FIFO
  spl_pkt_t  wr_pkt;
  logic      wr_stb;

  // FIFO back to decoder, stalls ack
  logic      full;

  // ------------------------------
  // symbol decode
  // ------------------------------

  spl_flit_decoder u_dec (
    .tb_clk   (tb_clk),
    .tb_rst   (tb_rst),
    .data     (data),
    .full     (full),
    .ack      (ack),
    .flit     (flit),
    .flit_stb (flit_stb),
    .flit_bad (flit_bad),
    .flt_err  (flt_err)
  );

  // ------------------------------
  // framing and buffering
  // ------------------------------

  spl_pkt_assembler u_asm (
    .tb_clk   (tb_clk),
    .tb_rst   (tb_rst),
    .flit     (flit),
    .flit_stb (flit_stb),
    .flit_bad (flit_bad),
    .wr_pkt   (wr_pkt),
    .wr_stb   (wr_stb),
    .frm_err  (frm_err)
  );

  spl_pkt_fifo #(
    .item_t     (spl_pkt_t),
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .tb_clk  (tb_clk),
    .tb_rst  (tb_rst),
    .wr_item (wr_pkt),
    .wr_stb  (wr_stb),
    .rd_item (pkt),
    .rd_vld  (pkt_vld),
    .rd_rdy  (pkt_rdy),
    .full    (full)
  );

endmodule

`default_nettype wire

// ==== verif/spl_rx_props.sv ====
// ------------------------------
// receiver properties
// link, error pulse and packet port rules
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module spl_rx_props
  import spl_rx_pkg::*;
(
  input logic                 tb_clk,
  input logic                 tb_rst,
  input logic [spl_sym_w-1:0] data,
  input logic                 ack,
  input spl_pkt_t             pkt,
  input logic                 pkt_vld,
  input logic                 pkt_rdy,
  input logic                 flt_err,
  input logic                 frm_err,
  input logic                 full
);

  // failure count read by the testbench at the end
  int n_fail = 0;

  // wires and ack one cycle back
  logic [spl_sym_w-1:0] data_d;
  logic                 ack_d;
  // sampled wire changes still waiting for their ack
  logic [3:0]           n_open;

  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      data_d <= '0;
      ack_d  <= 1'b0;
      n_open <= '0;
    end
    else
    begin
      data_d <= data;
      ack_d  <= ack;
      // a new change and an ack in the same cycle cancel out
      if ((data != data_d) && (ack == ack_d))
        n_open <= n_open + 1'b1;
      else if ((data == data_d) && (ack != ack_d))
        n_open <= n_open - 1'b1;
    end
  end

  // ------------------------------
  // reset and link
  // ------------------------------

  a_reset_state: assert property (@(posedge tb_clk)
    $fell(tb_rst) |-> !ack && !pkt_vld && !flt_err && !frm_err)
  else
  begin
    $error("outputs not idle after reset");
    n_fail++;
  end

  // one ack per sampled wire change
  a_ack_after_data: assert property (@(posedge tb_clk) disable iff (tb_rst)
    (ack != ack_d) |-> (n_open != '0))
  else
  begin
    $error("ack changed with no symbol pending");
    n_fail++;
  end

  // full FIFO stalls the sender
  a_ack_stall: assert property (@(posedge tb_clk) disable iff (tb_rst)
    full |=> $stable(ack))
  else
  begin
    $error("ack toggled while FIFO full");
    n_fail++;
  end

  // ------------------------------
  // error pulses and packet port
  // ------------------------------

  a_flt_pulse: assert property (@(posedge tb_clk) disable iff (tb_rst)
    flt_err |=> !flt_err)
  else
  begin
    $error("flt_err longer than one cycle");
    n_fail++;
  end

  a_frm_pulse: assert property (@(posedge tb_clk) disable iff (tb_rst)
    frm_err |=> !frm_err)
  else
  begin
    $error("frm_err longer than one cycle");
    n_fail++;
  end

  a_pkt_hold: assert property (@(posedge tb_clk) disable iff (tb_rst)
    pkt_vld && !pkt_rdy |=> pkt_vld && $stable(pkt))
  else
  begin
    $error("pkt dropped or changed while stalled");
    n_fail++;
  end

endmodule

bind spl_rx_top spl_rx_props u_props (
  .tb_clk  (tb_clk),
  .tb_rst  (tb_rst),
  .data    (data),
  .ack     (ack),
  .pkt     (pkt),
  .pkt_vld (pkt_vld),
  .pkt_rdy (pkt_rdy),
  .flt_err (flt_err),
  .frm_err (frm_err),
  .full    (full)
);

`default_nettype wire

// ==== verif/spl_rx_tb.sv ====
// ------------------------------
// spinnaker link receiver testbench
// 2-of-7 sender, packet sink and scoreboard
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module spl_rx_tb
  import spl_rx_pkg::*;
();

  // each frame sent is at most a long packet plus end-of-packet
  localparam int n_frames   = 33;
  localparam int max_syms   = n_frames * (spl_long_flits + 1);
  localparam int max_cycles = 40 * max_syms + 2000;

  // own code table constants
  localparam logic [6:0] eop_chg    = 7'b1100000;
  // wires 4 and 5 form a pair no nibble uses
  localparam logic [6:0] unused_chg = 7'b0110000;

  logic           tb_clk;
  logic           tb_rst;
  logic [6:0]     data;
  logic           ack;
  spl_pkt_t       pkt;
  logic           pkt_vld;
  logic           pkt_rdy;
  logic           flt_err;
  logic           frm_err;

  spl_pkt_t       exp_q[$];
  spl_pkt_t       exp_head;
  int             exp_cnt = 0;
  logic [31:0]    pkt_seed = 32'd21751;
  logic [31:0]    rdy_seed = 32'd21751;
  int             rdy_left = 0;
  logic           hold_rdy = 1'b0;
  int             n_err = 0;
  int             n_frm = 0;
  int             n_flt = 0;
  int             sym_cnt = 0;
  int             cyc = 0;

  spl_rx_top #(.fifo_depth(4)) u_spl_rx_top (
    .tb_clk  (tb_clk),
    .tb_rst  (tb_rst),
    .data    (data),
    .ack     (ack),
    .pkt     (pkt),
    .pkt_vld (pkt_vld),
    .pkt_rdy (pkt_rdy),
    .flt_err (flt_err),
    .frm_err (frm_err)
  );

  always #50 tb_clk = ~tb_clk;

  // ------------------------------
  // helpers
  // ------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // two wires per nibble
  function automatic logic [6:0] nib_to_chg(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'b0010001;
      4'h1: return 7'b0010010;
      4'h2: return 7'b0010100;
      4'h3: return 7'b0011000;
      4'h4: return 7'b0100001;
      4'h5: return 7'b0100010;
      4'h6: return 7'b0100100;
      4'h7: return 7'b0101000;
      4'h8: return 7'b1000001;
      4'h9: return 7'b1000010;
      4'ha: return 7'b1000100;
      4'hb: return 7'b1001000;
      4'hc: return 7'b0000011;
      4'hd: return 7'b0000110;
      4'he: return 7'b0001100;
      default: return 7'b0001001;
    endcase
  endfunction

  function automatic void refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt > 0) ? exp_q[0] : '0;
  endfunction

  // random key, payload and header with parity fixed last
  task automatic gen_pkt(input logic force_long, output spl_pkt_t p);
    pkt_seed = xorshift32(pkt_seed);
    p.key    = pkt_seed;
    pkt_seed = xorshift32(pkt_seed);
    p.pld    = pkt_seed;
    pkt_seed = xorshift32(pkt_seed);
    p.hdr    = pkt_seed[7:0];
    if (force_long)
      p.hdr[1] = 1'b1;
    // short packets carry no payload
    if (!p.hdr[1])
      p.pld = '0;
    p.hdr[0] = 1'b0;
    p.hdr[0] = ~(^p);
  endtask

  // flip two wires then wait for the ack toggle
  task automatic send_sym(input logic [6:0] chg);
    logic old_ack;
    old_ack = ack;
    data    = data ^ chg;
    sym_cnt++;
    while (ack == old_ack)
    begin
      @(posedge tb_clk);
      #1;
    end
  endtask

  // low nibble first
  // bad_idx swaps one nibble for an unused pair
  task automatic send_frame(input spl_pkt_t p, input int nflits, input int bad_idx);
    logic [spl_pkt_w-1:0] bits;
    int                   i;
    bits = p;
    for (i = 0; i < nflits; i++)
    begin
      if (i == bad_idx)
        send_sym(unused_chg);
      else
        send_sym(nib_to_chg(bits[i*spl_nib_w +: spl_nib_w]));
    end
    send_sym(eop_chg);
  endtask

  task automatic send_good();
    spl_pkt_t p;
    gen_pkt(1'b0, p);
    exp_q.push_back(p);
    refresh_head();
    send_frame(p, p.hdr[1] ? spl_long_flits : spl_short_flits, -1);
  endtask

  // ------------------------------
  // sink, counters, timeout
  // ------------------------------

  // random ready stretches that are mostly high
  always @(posedge tb_clk)
  begin
    #1;
    if (hold_rdy)
      pkt_rdy = 1'b0;
    else if (rdy_left == 0)
    begin
      rdy_seed = xorshift32(rdy_seed);
      pkt_rdy  = (rdy_seed[1:0] != 2'b00);
      rdy_left = int'(rdy_seed[4:2]);
    end
    else
      rdy_left--;
  end

  always @(posedge tb_clk)
  begin
    if (!tb_rst)
    begin
      if (pkt_vld && pkt_rdy && exp_cnt > 0)
      begin
        void'(exp_q.pop_front());
        refresh_head();
      end
      if (frm_err)
        n_frm++;
      if (flt_err)
        n_flt++;
    end
  end

  always @(posedge tb_clk)
  begin
    cyc++;
    if (cyc >= max_cycles)
    begin
      $display("timeout after %0d cycles with %0d symbols sent", cyc, sym_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  // ------------------------------
  // packet checks
  // ------------------------------

  a_pkt_expected: assert property (@(posedge tb_clk) disable iff (tb_rst)
    (pkt_vld && pkt_rdy) |-> (exp_cnt > 0))
  else
  begin
    n_err++;
    $display("packet delivered that was never sent");
  end

  a_pkt_key: assert property (@(posedge tb_clk) disable iff (tb_rst)
    (pkt_vld && pkt_rdy && exp_cnt > 0) |-> (pkt.key == exp_head.key))
  else
  begin
    n_err++;
    $display("mismatch at %0t: pkt.key got %h expected %h",
             $time, $sampled(pkt.key), $sampled(exp_head.key));
  end

  a_pkt_hdr: assert property (@(posedge tb_clk) disable iff (tb_rst)
    (pkt_vld && pkt_rdy && exp_cnt > 0) |-> (pkt.hdr == exp_head.hdr))
  else
  begin
    n_err++;
    $display("mismatch at %0t: pkt.hdr got %h expected %h",
             $time, $sampled(pkt.hdr), $sampled(exp_head.hdr));
  end

  // expected payload is already zero for short packets
  a_pkt_pld: assert property (@(posedge tb_clk) disable iff (tb_rst)
    (pkt_vld && pkt_rdy && exp_cnt > 0) |-> (pkt.pld == exp_head.pld))
  else
  begin
    n_err++;
    $display("mismatch at %0t: pkt.pld got %h expected %h",
             $time, $sampled(pkt.pld), $sampled(exp_head.pld));
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  initial
  begin
    spl_pkt_t bad;
    int       n_prop;
    tb_clk  = 1'b0;
    tb_rst  = 1'b1;
    data    = '0;
    pkt_rdy = 1'b0;
    refresh_head();
    repeat (2) @(posedge tb_clk);
    #1 tb_rst = 1'b0;
    @(posedge tb_clk);
    #1;

    // mixed short and long traffic
    repeat (24) send_good();

    // unused wire pair inside a frame
    gen_pkt(1'b0, bad);
    send_frame(bad, bad.hdr[1] ? spl_long_flits : spl_short_flits, 3);
    // even packet xor
    gen_pkt(1'b0, bad);
    bad.hdr[0] = ~bad.hdr[0];
    send_frame(bad, bad.hdr[1] ? spl_long_flits : spl_short_flits, -1);
    // long header but a short frame
    gen_pkt(1'b1, bad);
    send_frame(bad, spl_short_flits, -1);

    // hold the sink until the FIFO fills and the link stalls
    @(posedge tb_clk);
    hold_rdy = 1'b1;
    #1;
    fork
      repeat (6) send_good();
      begin
        while (!u_spl_rx_top.full)
          @(posedge tb_clk);
        repeat (40) @(posedge tb_clk);
        hold_rdy = 1'b0;
      end
    join

    // drain and let the last pulses settle
    while (exp_cnt != 0 || pkt_vld)
      @(posedge tb_clk);
    repeat (5) @(posedge tb_clk);

    a_frm_count: assert (n_frm == 3)
    else
    begin
      n_err++;
      $display("mismatch at %0t: frm_err pulses got %0d expected 3", $time, n_frm);
    end
    a_flt_count: assert (n_flt == 1)
    else
    begin
      n_err++;
      $display("mismatch at %0t: flt_err pulses got %0d expected 1", $time, n_flt);
    end

    n_prop = u_spl_rx_top.u_props.n_fail;
    $display("errors: %0d testbench, %0d property, %0d symbols sent", n_err, n_prop, sym_cnt);
    if (n_err == 0 && n_prop == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/spl_rx_pkg.sv
rtl/spl_flit_decoder.sv
rtl/spl_pkt_assembler.sv
rtl/spl_pkt_fifo.sv
rtl/spl_rx_top.sv
verif/spl_rx_props.sv
verif/spl_rx_tb.sv

// ==== Bender.yml ====
package:
  name: spl_rx

sources:
  # package first, then leaf blocks and top level
  - rtl/spl_rx_pkg.sv
  - rtl/spl_flit_decoder.sv
  - rtl/spl_pkt_assembler.sv
  - rtl/spl_pkt_fifo.sv
  - rtl/spl_rx_top.sv
  - target: simulation
    files:
      - verif/spl_rx_props.sv
      - verif/spl_rx_tb.sv
